/* Bender.yml */
package:
  name: fetch_top

sources:
  - fetch_pkg.sv
  - icache_pkg.sv
  - icache_tag.sv
  - icache_data.sv
  - icache_refill.sv
  - if_stage.sv
  - fetch_top.sv
  - target: simulation
    files:
      - tb_fetch_top.sv

/* build.f */
fetch_pkg.sv
icache_pkg.sv
icache_tag.sv
icache_data.sv
icache_refill.sv
if_stage.sv
fetch_top.sv
tb_fetch_top.sv

/* fetch_pkg.sv */
package fetch_pkg;

    localparam int WORD_BITS = 32;
    localparam int ADDR_BITS = 32;

    typedef logic [WORD_BITS-1:0] word_t;
    typedef logic [ADDR_BITS-1:0] addr_t;

    // addi x0, x0, 0.
    localparam word_t NOP = 32'h0000_0013;

    localparam addr_t PC_RESET = 32'h0000_0000;  // First fetch address.

    // Fetch FSM. The miss state holds the PC until the line is filled.
    typedef enum logic {
        IF_IDLE,     // Looking up the PC every cycle.
        IF_IC_MISS   // Waiting for the refill unit.
    } if_state_e;

endpackage : fetch_pkg

/* fetch_top.sv */
`timescale 1ns/1ps

module fetch_top import fetch_pkg::*, icache_pkg::*; (
    input  logic     clk_i,
    input  logic     reset_i,

    // Decode.
    output word_t    instr_o,
    output addr_t    pc_o,
    output logic     hazard_o,
    input  logic     hazard_i,

    // Writeback.
    input  logic     tkbr_i,
    input  addr_t    new_pc_i,

    // Memory.
    output logic     mem_req_o,
    output addr_t    mem_addr_o,
    input  logic     mem_rsp_valid_i,
    input  ic_lane_t mem_rsp_data_i
);

    logic     miss;
    addr_t    miss_addr;
    ic_fill_t fill;

    if_stage if_stage_inst (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .hazard_i    (hazard_i),
        .tkbr_i      (tkbr_i),
        .new_pc_i    (new_pc_i),
        .fill_i      (fill),
        .instr_o     (instr_o),
        .pc_o        (pc_o),
        .hazard_o    (hazard_o),
        .miss_o      (miss),
        .miss_addr_o (miss_addr)
    );

    icache_refill icache_refill_inst (
        .clk_i           (clk_i),
        .reset_i         (reset_i),
        .miss_i          (miss),
        .miss_addr_i     (miss_addr),
        .mem_req_o       (mem_req_o),
        .mem_addr_o      (mem_addr_o),
        .mem_rsp_valid_i (mem_rsp_valid_i),
        .mem_rsp_data_i  (mem_rsp_data_i),
        .fill_o          (fill)
    );

endmodule : fetch_top

/* icache_data.sv */
`timescale 1ns/1ps

module icache_data import fetch_pkg::*, icache_pkg::*; (
    input  logic       clk_i,
    input  ic_index_t  index_i,
    input  ic_offset_t offset_i,
    input  ic_fill_t   fill_i,
    output word_t      word_o
);

    ic_lane_t lane_q [IC_LINES];
    ic_lane_t rd_lane;

    // Whole lane written in one cycle.
    always_ff @(posedge clk_i) begin
        if (fill_i.valid) begin
            lane_q[fill_i.index] <= fill_i.lane;
        end
    end

    assign rd_lane = lane_q[index_i];

    // Word 0 sits in the low bits of the lane.
    assign word_o = rd_lane[offset_i*WORD_BITS +: WORD_BITS];

endmodule : icache_data

/* icache_pkg.sv */
package icache_pkg;

    localparam int IC_ADDR_BITS     = 32;
    localparam int IC_LINES         = 4;
    localparam int IC_LANE_BITS     = 128;
    localparam int IC_BYTE_BITS     = 4;                         // Byte offset in a lane.
    localparam int IC_INDEX_BITS    = 2;
    localparam int IC_WORD_SEL_BITS = IC_BYTE_BITS - 2;          // Word in a lane.
    localparam int IC_TAG_BITS      = IC_ADDR_BITS - IC_BYTE_BITS;

    typedef logic [IC_INDEX_BITS-1:0]    ic_index_t;
    typedef logic [IC_WORD_SEL_BITS-1:0] ic_offset_t;
    typedef logic [IC_TAG_BITS-1:0]      ic_tag_t;
    typedef logic [IC_LANE_BITS-1:0]     ic_lane_t;

    // Result of the parallel tag compare.
    typedef struct packed {
        logic      hit;
        logic      miss;
        ic_index_t index;  // Matching line, meaningful on a hit.
    } ic_lookup_t;

    // One-cycle line write from the refill unit.
    typedef struct packed {
        logic      valid;
        ic_index_t index;
        ic_tag_t   tag;
        ic_lane_t  lane;
    } ic_fill_t;

endpackage : icache_pkg

/* icache_refill.sv */
`timescale 1ns/1ps

module icache_refill import fetch_pkg::*, icache_pkg::*; (
    input  logic     clk_i,
    input  logic     reset_i,
    input  logic     miss_i,
    input  addr_t    miss_addr_i,
    output logic     mem_req_o,
    output addr_t    mem_addr_o,
    input  logic     mem_rsp_valid_i,
    input  ic_lane_t mem_rsp_data_i,
    output ic_fill_t fill_o
);

    typedef enum logic [1:0] {
        RF_IDLE,
        RF_WAIT,  // Request sent, lane not back yet.
        RF_FILL   // Writing the lane into the cache.
    } rf_state_e;

    rf_state_e state_q;
    addr_t     addr_q;
    ic_lane_t  lane_q;
    ic_index_t victim_q;
    logic      req_q;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q  <= RF_IDLE;
            req_q    <= 1'b0;
            victim_q <= '0;
        end else begin
            req_q <= 1'b0;  // Request is a single pulse.
            unique case (state_q)
                RF_IDLE: begin
                    if (miss_i) begin
                        state_q <= RF_WAIT;
                        req_q   <= 1'b1;
                    end
                end
                RF_WAIT: begin
                    if (mem_rsp_valid_i) state_q <= RF_FILL;
                end
                RF_FILL: begin
                    state_q  <= RF_IDLE;
                    victim_q <= ic_index_t'((victim_q + 1) % IC_LINES);  // Round robin.
                end
                default: state_q <= RF_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == RF_IDLE && miss_i) addr_q <= miss_addr_i;
        if (state_q == RF_WAIT && mem_rsp_valid_i) lane_q <= mem_rsp_data_i;
    end

    assign mem_req_o  = req_q;
    assign mem_addr_o = addr_q;  // Held for the whole wait.

    always_comb begin
        fill_o.valid = (state_q == RF_FILL);
        fill_o.index = victim_q;
        fill_o.tag   = addr_q[IC_ADDR_BITS-1:IC_BYTE_BITS];
        fill_o.lane  = lane_q;
    end

    // Memory answers only the one outstanding request.
    assert property (@(posedge clk_i) disable iff (reset_i)
        mem_rsp_valid_i |-> state_q == RF_WAIT);

endmodule : icache_refill

/* icache_tag.sv */
`timescale 1ns/1ps

module icache_tag import icache_pkg::*; (
    input  logic       clk_i,
    input  logic       reset_i,
    input  ic_tag_t    tag_i,
    input  ic_fill_t   fill_i,
    output ic_lookup_t lookup_o
);

    ic_tag_t             tag_q [IC_LINES];
    logic [IC_LINES-1:0] valid_q;
    logic [IC_LINES-1:0] match;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            valid_q <= '0;
        end else if (fill_i.valid) begin
            valid_q[fill_i.index] <= 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (fill_i.valid) begin
            tag_q[fill_i.index] <= fill_i.tag;
        end
    end

    // All lines compared at once.
    always_comb begin
        for (int i = 0; i < IC_LINES; i++) begin
            match[i] = valid_q[i] && (tag_q[i] == tag_i);
        end
    end

    always_comb begin
        lookup_o.hit   = |match;
        lookup_o.miss  = ~|match;
        lookup_o.index = '0;
        for (int i = IC_LINES - 1; i >= 0; i--) begin
            if (match[i]) lookup_o.index = ic_index_t'(i);  // Lowest match wins.
        end
    end

    // Refills only follow misses, so a tag never lives in two lines.
    for (genvar i = 0; i < IC_LINES; i++) begin : g_uniq_i
        for (genvar j = i + 1; j < IC_LINES; j++) begin : g_uniq_j
            assert property (@(posedge clk_i) disable iff (reset_i)
                !(valid_q[i] && valid_q[j] && tag_q[i] == tag_q[j]));
        end
    end

endmodule : icache_tag

/* if_stage.sv */
`timescale 1ns/1ps

module if_stage import fetch_pkg::*, icache_pkg::*; (
    input  logic     clk_i,
    input  logic     reset_i,
    input  logic     hazard_i,
    input  logic     tkbr_i,
    input  addr_t    new_pc_i,
    input  ic_fill_t fill_i,
    output word_t    instr_o,
    output addr_t    pc_o,
    output logic     hazard_o,
    output logic     miss_o,
    output addr_t    miss_addr_o
);

    addr_t      fetch_pc;
    addr_t      nxt_pc;
    if_state_e  state_q;
    if_state_e  state_d;
    ic_lookup_t lookup;
    word_t      ic_word;

    icache_tag icache_tag_inst (
        .clk_i    (clk_i),
        .reset_i  (reset_i),
        .tag_i    (fetch_pc[IC_ADDR_BITS-1:IC_BYTE_BITS]),
        .fill_i   (fill_i),
        .lookup_o (lookup)
    );

    icache_data icache_data_inst (
        .clk_i    (clk_i),
        .index_i  (lookup.index),
        .offset_i (fetch_pc[IC_BYTE_BITS-1:2]),
        .fill_i   (fill_i),
        .word_o   (ic_word)
    );

    // Only a fresh miss in IF_IDLE starts a refill.
    assign miss_o      = (state_q == IF_IDLE) && lookup.miss;
    assign miss_addr_o = {fetch_pc[IC_ADDR_BITS-1:IC_BYTE_BITS], {IC_BYTE_BITS{1'b0}}};
    assign hazard_o    = (state_q == IF_IC_MISS) || miss_o;

    always_comb begin
        state_d = state_q;
        unique case (state_q)
            IF_IDLE: begin
                if (lookup.miss) state_d = IF_IC_MISS;
            end
            IF_IC_MISS: begin
                if (fill_i.valid) state_d = IF_IDLE;  // Line is in, retry the PC.
            end
            default: state_d = IF_IDLE;
        endcase
    end

    // Branch first, then advance on an accepted hit, else hold.
    always_comb begin
        if (tkbr_i) begin
            nxt_pc = new_pc_i;
        end else if (!hazard_o && !hazard_i) begin
            nxt_pc = fetch_pc + 32'd4;
        end else begin
            nxt_pc = fetch_pc;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q  <= IF_IDLE;
            fetch_pc <= PC_RESET;
            instr_o  <= NOP;
            pc_o     <= PC_RESET;
        end else begin
            state_q  <= state_d;
            fetch_pc <= nxt_pc;
            if (hazard_o || tkbr_i) begin
                instr_o <= NOP;  // Bubble, the wrong-path slot too.
            end else if (!hazard_i) begin
                instr_o <= ic_word;
                pc_o    <= fetch_pc;
            end
        end
    end

    // The refill unit writes only in answer to a miss.
    assert property (@(posedge clk_i) disable iff (reset_i)
        fill_i.valid |-> state_q == IF_IC_MISS);

endmodule : if_stage

/* tb_fetch_top.sv */
`timescale 1ns/1ps

module tb_fetch_top import fetch_pkg::*, icache_pkg::*; ();

    localparam int CLK_PERIOD     = 40;
    localparam int PLANNED_INSTRS = 63;
    localparam int TIMEOUT_CYCLES = PLANNED_INSTRS * 200 + 500;

    logic     clk_i = 1'b0;
    logic     reset_i;
    word_t    instr_o;
    addr_t    pc_o;
    logic     hazard_o;
    logic     hazard_i;
    logic     tkbr_i;
    addr_t    new_pc_i;
    logic     mem_req_o;
    addr_t    mem_addr_o;
    logic     mem_rsp_valid_i;
    ic_lane_t mem_rsp_data_i;

    addr_t model_pc;
    addr_t exp_pc_q;
    logic  took_q;
    logic  bubble_q;
    logic  stall_q;
    logic  in_refill;
    logic  fill_next;
    int    accepted  = 0;
    int    req_count = 0;
    addr_t last_req_addr;
    addr_t exp_req_q [$];   // Lane addresses of misses not yet requested.
    word_t last_instr;
    addr_t last_pc;

    fetch_top fetch_top_inst (.*);

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    // Memory contents are a function of the address.
    function automatic word_t expected_word(input addr_t a);
        return a ^ 32'hA5A5_0000;
    endfunction

    function automatic ic_lane_t build_lane(input addr_t base);
        ic_lane_t lane;
        for (int i = 0; i < IC_LANE_BITS / 32; i++) begin
            lane[i*32 +: 32] = expected_word(base + addr_t'(4 * i));
        end
        return lane;
    endfunction

    task automatic stop_on_failure(input string what);
        $display("%s", what);
        $display("ERRORS FOUND");
        $fatal(1, "Simulation stopped at the first error.");
    endtask

    task automatic check_word(input word_t got, input word_t exp, input string name);
        if (got !== exp)
            stop_on_failure($sformatf("ERROR at %0t ns: %s is %h, expected %h",
                                      $time, name, got, exp));
    endtask

    task automatic check_addr(input addr_t got, input addr_t exp, input string name);
        if (got !== exp)
            stop_on_failure($sformatf("ERROR at %0t ns: %s is %h, expected %h",
                                      $time, name, got, exp));
    endtask

    task automatic check_lane_addr(input addr_t got, input addr_t exp, input string name);
        if (got !== exp)
            stop_on_failure($sformatf("ERROR at %0t ns: %s is %h, expected %h",
                                      $time, name, got, exp));
    endtask

    task automatic expect_requests(input string phase, input int base, input int n);
        if (req_count - base != n)
            stop_on_failure($sformatf("%s issued %0d memory requests instead of %0d",
                                      phase, req_count - base, n));
    endtask

    // Called on a falling edge. Random stalls when stall is set.
    task automatic run_instrs(input int n, input bit stall);
        int target;
        target = accepted + n;
        while (accepted < target) begin
            @(negedge clk_i);
            hazard_i = stall && ($urandom_range(0, 3) == 0);
        end
        hazard_i = 1'b0;
    endtask

    task automatic branch_to(input addr_t target);
        tkbr_i   = 1'b1;
        new_pc_i = target;
        @(negedge clk_i);
        tkbr_i   = 1'b0;
    endtask

    // Model of the fetch stream, sampled on the rising edge.
    always @(posedge clk_i) begin : track_pc
        if (reset_i) begin
            model_pc  <= PC_RESET;
            took_q    <= 1'b0;
            bubble_q  <= 1'b0;
            stall_q   <= 1'b0;
            in_refill <= 1'b0;
            fill_next <= 1'b0;
        end else begin
            took_q    <= !hazard_o && !hazard_i && !tkbr_i;
            bubble_q  <= hazard_o || tkbr_i;
            stall_q   <= hazard_i && !hazard_o && !tkbr_i;
            exp_pc_q  <= model_pc;
            fill_next <= mem_rsp_valid_i;
            if (!hazard_o && !hazard_i && !tkbr_i) accepted <= accepted + 1;
            if (tkbr_i) begin
                model_pc <= new_pc_i;
            end else if (!hazard_o && !hazard_i) begin
                model_pc <= model_pc + 32'd4;
            end
            if (hazard_o && !in_refill) begin
                in_refill <= 1'b1;  // A new miss on the model PC.
                exp_req_q.push_back(model_pc & ~addr_t'(IC_LANE_BITS / 8 - 1));
            end else if (fill_next) begin
                in_refill <= 1'b0;
            end
        end
    end

    always @(negedge clk_i) begin : compare_outputs
        if (took_q) begin
            check_word(instr_o, expected_word(exp_pc_q), "instr_o");
            check_addr(pc_o, exp_pc_q, "pc_o");
        end else if (bubble_q) begin
            check_word(instr_o, NOP, "instr_o");
            check_addr(pc_o, last_pc, "pc_o");
        end else if (stall_q) begin
            check_word(instr_o, last_instr, "instr_o");
            check_addr(pc_o, last_pc, "pc_o");
        end
        last_instr = instr_o;
        last_pc    = pc_o;
    end

    initial begin : memory_model
        int unsigned delay;
        mem_rsp_valid_i = 1'b0;
        mem_rsp_data_i  = '0;
        forever begin
            @(negedge clk_i);
            if (mem_req_o) begin
                if (exp_req_q.size() == 0) begin
                    stop_on_failure("A memory request was issued without a cache miss");
                end else begin
                    check_lane_addr(mem_addr_o, exp_req_q.pop_front(), "mem_addr_o");
                end
                req_count++;
                last_req_addr = mem_addr_o;
                delay = $urandom_range(1, 8);
                repeat (delay) begin
                    @(negedge clk_i);
                    if (mem_req_o) stop_on_failure("A second request came while one was open");
                end
                check_lane_addr(mem_addr_o, last_req_addr, "mem_addr_o");  // Held.
                mem_rsp_valid_i = 1'b1;
                mem_rsp_data_i  = build_lane(mem_addr_o);
                @(negedge clk_i);
                mem_rsp_valid_i = 1'b0;
                mem_rsp_data_i  = '0;
            end
        end
    end

    initial begin : watchdog
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        stop_on_failure("Timeout: the fetch stage stopped delivering instructions");
    end

    initial begin : stimulus
        int base;
        void'($urandom(32'h05b7_32f4));
        reset_i  = 1'b1;
        hazard_i = 1'b0;
        tkbr_i   = 1'b0;
        new_pc_i = '0;
        repeat (4) @(negedge clk_i);
        check_word(instr_o, NOP, "instr_o");
        check_addr(pc_o, PC_RESET, "pc_o");
        if (mem_req_o !== 1'b0) stop_on_failure("mem_req_o is not low during reset");
        reset_i = 1'b0;

        // Four cold lines, then branch while the last line still hits.
        base = req_count;
        run_instrs(15, 1'b0);
        branch_to(32'h0000_0000);
        expect_requests("Sequential fetch", base, 4);

        base = req_count;
        run_instrs(15, 1'b0);
        branch_to(32'h0000_0040);
        expect_requests("Loop over cached lines", base, 0);

        // Fifth line evicts the first one.
        base = req_count;
        run_instrs(3, 1'b0);
        branch_to(32'h0000_0000);
        run_instrs(3, 1'b0);
        expect_requests("Replacement", base, 2);
        check_lane_addr(last_req_addr, 32'h0000_0000, "mem_addr_o");

        // Redirect while the refill for 0x100 is still open.
        base = req_count;
        branch_to(32'h0000_0100);
        do @(negedge clk_i); while (!mem_req_o);
        branch_to(32'h0000_0200);
        run_instrs(1, 1'b0);
        check_addr(pc_o, 32'h0000_0200, "pc_o");
        run_instrs(2, 1'b0);
        expect_requests("Branch during refill", base, 2);

        base = req_count;
        run_instrs(24, 1'b1);
        expect_requests("Fetch with stalls", base, 6);

        if (exp_req_q.size() != 0 || in_refill) begin
            stop_on_failure("A cache miss ended without its memory request");
        end else begin
            $display("NO ERRORS");
            $finish;
        end
    end

endmodule : tb_fetch_top
